/* rtl/tart_pkg.sv */
`default_nettype none

package tart_pkg;

   // --------------------------------------------------------------------------
   // Array sizes
   // --------------------------------------------------------------------------
   localparam int NUM_ANTENNA   = 4;
   localparam int NUM_BASELINES = 6;   // All pairs of four antennas
   localparam int ACCUM_BITS    = 16;  // Per-baseline agreement count

   // Register bus
   localparam int BUS_BITS = 8;
   localparam int ADR_BITS = 5;

   // Block size as log2 of the sample count
   localparam int BLOCK_LOG2_BITS    = 4;
   localparam int BLOCK_LOG2_DEFAULT = 4;                   // 16 samples
   localparam int BLOCK_LOG2_MAX     = 12;                  // 4096 samples
   localparam int CNT_BITS           = BLOCK_LOG2_MAX + 1;  // Sample counter width

   // Read port toward the bank
   localparam int BLK_BITS    = 4;             // Block counter, status byte
   localparam int SEL_BITS    = 3;             // Baseline index
   localparam int RD_ADR_BITS = SEL_BITS + 1;  // Index plus byte select

   // --------------------------------------------------------------------------
   // Address map
   // --------------------------------------------------------------------------
   localparam logic [ADR_BITS-1:0] ADR_CTRL     = ADR_BITS'(0);
   localparam logic [ADR_BITS-1:0] ADR_BLOCK    = ADR_BITS'(1);
   localparam logic [ADR_BITS-1:0] ADR_STATUS   = ADR_BITS'(2);
   localparam logic [ADR_BITS-1:0] ADR_VIS_BASE = ADR_BITS'(16);  // Low byte first

   // Control register fields
   localparam int CTRL_ENABLE_BIT    = 0;
   localparam int CTRL_OVERWRITE_BIT = 1;

   // Antenna indices of each baseline
   // (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
   localparam int BASELINE_A [NUM_BASELINES] = '{0, 0, 0, 1, 1, 2};
   localparam int BASELINE_B [NUM_BASELINES] = '{1, 2, 3, 2, 3, 3};

   // One visibility count
   typedef logic [ACCUM_BITS-1:0] vis_t;

endpackage

`default_nettype wire

/* rtl/tart_ifs.sv */
`default_nettype none

// Fanout to correlators, correlators to bank
interface corr_feed_if;
   import tart_pkg::*;

   logic                     valid;   // Registered sample strobe
   logic                     first;   // First sample of a block
   logic                     last;    // Final sample of a block
   logic [NUM_BASELINES-1:0] pair_a;  // First antenna of each pair
   logic [NUM_BASELINES-1:0] pair_b;  // Second antenna of each pair

   // One entry per correlator
   logic vis_done  [NUM_BASELINES];
   vis_t vis_value [NUM_BASELINES];

   modport fanout (output valid, first, last, pair_a, pair_b);

   modport correlator (
      input  valid, first, last, pair_a, pair_b,
      output vis_done, vis_value
   );

   modport bank (input vis_done, vis_value);

endinterface

// Register file to visibility bank
interface vis_read_if;
   import tart_pkg::*;

   logic [RD_ADR_BITS-1:0] rd_addr;    // {baseline, byte select}
   logic                   rd_stb;     // Acknowledged visibility read
   logic                   clr_ovf;    // Status register write
   logic [BUS_BITS-1:0]    rd_data;
   logic                   available;
   logic                   overflow;
   logic [BLK_BITS-1:0]    blk_count;

   modport regs (
      output rd_addr, rd_stb, clr_ovf,
      input  rd_data, available, overflow, blk_count
   );

   modport bank (
      input  rd_addr, rd_stb, clr_ovf,
      output rd_data, available, overflow, blk_count
   );

endinterface

`default_nettype wire

/* rtl/baseline_fanout.sv */
`default_nettype none

module baseline_fanout (
   input  logic                                 b_clk,
   input  logic                                 rst_i,
   input  logic                                 enable_i,
   input  logic [tart_pkg::BLOCK_LOG2_BITS-1:0] block_log2_i,
   input  logic                                 ax_valid_i,
   input  logic [tart_pkg::NUM_ANTENNA-1:0]     antenna_i,
   corr_feed_if.fanout                          feed
);
   import tart_pkg::*;

   logic [CNT_BITS-1:0]        cnt_q;     // Samples so far in this block
   logic [BLOCK_LOG2_BITS-1:0] log2_q;    // Size held for the running block
   logic [BLOCK_LOG2_BITS-1:0] log2_now;
   logic [CNT_BITS-1:0]        last_cnt;  // Index of the final sample
   logic                       start;
   logic                       finish;

   // --------------------------------------------------------------------------
   // Block boundaries
   // --------------------------------------------------------------------------
   assign start    = (cnt_q == '0);
   assign log2_now = start ? block_log2_i : log2_q;  // New size only at block start
   assign last_cnt = (CNT_BITS'(1) << log2_now) - 1'b1;
   assign finish   = (cnt_q == last_cnt);

   always_ff @(posedge b_clk) begin
      if (rst_i || !enable_i) begin  // Partial block thrown away
         cnt_q      <= '0;
         log2_q     <= BLOCK_LOG2_BITS'(BLOCK_LOG2_DEFAULT);
         feed.valid <= 1'b0;
         feed.first <= 1'b0;
         feed.last  <= 1'b0;
      end else begin
         feed.valid <= ax_valid_i;
         feed.first <= ax_valid_i && start;
         feed.last  <= ax_valid_i && finish;
         if (ax_valid_i) begin
            cnt_q <= finish ? '0 : cnt_q + 1'b1;  // Wrap into the next block
            if (start) begin
               log2_q <= block_log2_i;
            end
         end
      end
   end

   // --------------------------------------------------------------------------
   // Pair bits from the baseline tables
   // --------------------------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (ax_valid_i) begin
         for (int k = 0; k < NUM_BASELINES; k++) begin
            feed.pair_a[k] <= antenna_i[BASELINE_A[k]];
            feed.pair_b[k] <= antenna_i[BASELINE_B[k]];
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/baseline_correlator.sv */
`default_nettype none

module baseline_correlator #(
   parameter int IDX = 0  // Baseline served by this copy
) (
   input  logic             b_clk,
   input  logic             rst_i,
   corr_feed_if.correlator  feed
);
   import tart_pkg::*;

   vis_t acc_q;   // Running agreement count
   logic done_q;  // Count complete
   logic agree;   // Both antennas gave the same bit

   assign agree = ~(feed.pair_a[IDX] ^ feed.pair_b[IDX]);

   // First sample restarts the count
   always_ff @(posedge b_clk) begin
      if (feed.valid) begin
         acc_q <= feed.first ? vis_t'(agree) : acc_q + vis_t'(agree);
      end
   end

   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         done_q <= 1'b0;
      end else begin
         done_q <= feed.valid && feed.last;  // One-cycle pulse
      end
   end

   // Held until the next valid sample, which the bank never waits on
   assign feed.vis_done[IDX]  = done_q;
   assign feed.vis_value[IDX] = acc_q;

endmodule

`default_nettype wire

/* rtl/visibility_bank.sv */
`default_nettype none

module visibility_bank (
   input  logic       b_clk,
   input  logic       rst_i,
   input  logic       overwrite_i,
   corr_feed_if.bank  feed,
   vis_read_if.bank   rd,
   output logic       newblock_o
);
   import tart_pkg::*;

   vis_t                vis_q [NUM_BASELINES];  // Captured block
   logic                done_all;               // Every correlator finished
   logic                keep;                   // Finished block goes into the bank
   logic                store_q;                // Block stored on the last edge
   logic                last_read;              // Final byte read back
   logic [SEL_BITS-1:0] sel;
   vis_t                word;

   always_comb begin
      done_all = 1'b1;
      for (int k = 0; k < NUM_BASELINES; k++) begin
         done_all &= feed.vis_done[k];
      end
   end

   // Full bank blocks a new one unless overwriting
   assign keep = done_all && (!rd.available || overwrite_i);

   // --------------------------------------------------------------------------
   // Capture
   // --------------------------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (keep) begin
         for (int k = 0; k < NUM_BASELINES; k++) begin
            vis_q[k] <= feed.vis_value[k];
         end
      end
   end

   // --------------------------------------------------------------------------
   // Flags and block counter
   // --------------------------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         store_q      <= 1'b0;
         newblock_o   <= 1'b0;
         rd.available <= 1'b0;
         rd.overflow  <= 1'b0;
         rd.blk_count <= '0;
      end else begin
         store_q    <= keep;
         newblock_o <= store_q;  // Stored blocks only
         if (store_q) begin
            rd.available <= 1'b1;
            rd.blk_count <= rd.blk_count + 1'b1;
         end else if (last_read) begin
            rd.available <= 1'b0;
         end
         if (done_all && !keep) begin  // Dropped block, old data kept
            rd.overflow <= 1'b1;
         end else if (rd.clr_ovf) begin
            rd.overflow <= 1'b0;
         end
      end
   end

   // --------------------------------------------------------------------------
   // Read port
   // --------------------------------------------------------------------------
   assign sel       = rd.rd_addr[RD_ADR_BITS-1:1];
   assign last_read = rd.rd_stb && rd.rd_addr[0] && (sel == SEL_BITS'(NUM_BASELINES - 1));

   always_comb begin
      word       = (sel < SEL_BITS'(NUM_BASELINES)) ? vis_q[sel] : '0;
      rd.rd_data = rd.rd_addr[0] ? word[ACCUM_BITS-1:BUS_BITS] : word[BUS_BITS-1:0];
   end

endmodule

`default_nettype wire

/* rtl/tart_control_regs.sv */
`default_nettype none

module tart_control_regs (
   input  logic                                 b_clk,
   input  logic                                 rst_i,
   input  logic                                 b_cyc_i,
   input  logic                                 b_stb_i,
   input  logic                                 b_we_i,
   input  logic [tart_pkg::ADR_BITS-1:0]        b_adr_i,
   input  logic [tart_pkg::BUS_BITS-1:0]        b_dat_i,
   output logic [tart_pkg::BUS_BITS-1:0]        b_dat_o,
   output logic                                 b_ack_o,
   output logic                                 enable_o,
   output logic                                 overwrite_o,
   output logic [tart_pkg::BLOCK_LOG2_BITS-1:0] block_log2_o,
   vis_read_if.regs                             rd
);
   import tart_pkg::*;

   logic                served_q;  // Strobe already acknowledged
   logic                req;       // Acknowledge on the next edge
   logic                vis_hit;   // Address in the visibility window
   logic [BUS_BITS-1:0] status;
   logic [BUS_BITS-1:0] rd_mux;

   // --------------------------------------------------------------------------
   // Bus handshake and decoding
   // --------------------------------------------------------------------------
   assign req     = b_cyc_i && b_stb_i && !b_ack_o && !served_q;
   assign vis_hit = (b_adr_i >= ADR_VIS_BASE) && (b_adr_i < ADR_VIS_BASE + 2 * NUM_BASELINES);

   assign rd.rd_addr = RD_ADR_BITS'(b_adr_i - ADR_VIS_BASE);
   assign rd.rd_stb  = req && !b_we_i && vis_hit;
   assign rd.clr_ovf = req && b_we_i && (b_adr_i == ADR_STATUS);

   assign status = {rd.blk_count, 2'b00, rd.overflow, rd.available};

   always_comb begin
      rd_mux = '0;  // Unused addresses
      if (vis_hit) begin
         rd_mux = rd.rd_data;
      end else begin
         case (b_adr_i)
            ADR_CTRL: begin
               rd_mux[CTRL_ENABLE_BIT]    = enable_o;
               rd_mux[CTRL_OVERWRITE_BIT] = overwrite_o;
            end
            ADR_BLOCK:  rd_mux = BUS_BITS'(block_log2_o);
            ADR_STATUS: rd_mux = status;
            default:    rd_mux = '0;
         endcase
      end
   end

   // --------------------------------------------------------------------------
   // Registers
   // --------------------------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         b_ack_o      <= 1'b0;
         served_q     <= 1'b0;
         enable_o     <= 1'b0;
         overwrite_o  <= 1'b0;
         block_log2_o <= BLOCK_LOG2_BITS'(BLOCK_LOG2_DEFAULT);
      end else begin
         b_ack_o  <= req;
         served_q <= b_cyc_i && b_stb_i && (served_q || b_ack_o);  // Until strobe drops
         if (req && b_we_i) begin
            case (b_adr_i)
               ADR_CTRL: begin
                  enable_o    <= b_dat_i[CTRL_ENABLE_BIT];
                  overwrite_o <= b_dat_i[CTRL_OVERWRITE_BIT];
               end
               ADR_BLOCK:
                  block_log2_o <= (b_dat_i > BUS_BITS'(BLOCK_LOG2_MAX)) ?
                                  BLOCK_LOG2_BITS'(BLOCK_LOG2_MAX) :
                                  b_dat_i[BLOCK_LOG2_BITS-1:0];
               default: ;  // Status write only clears overflow
            endcase
         end
      end
   end

   // Read data lines up with the acknowledge
   always_ff @(posedge b_clk) begin
      if (req) begin
         b_dat_o <= rd_mux;
      end
   end

endmodule

`default_nettype wire

/* rtl/tart_correlator_top.sv */
`default_nettype none

module tart_correlator_top (
   input  logic                             b_clk,
   input  logic                             rst_i,

   // Register bus
   input  logic                             b_cyc_i,
   input  logic                             b_stb_i,
   input  logic                             b_we_i,
   input  logic [tart_pkg::ADR_BITS-1:0]    b_adr_i,
   input  logic [tart_pkg::BUS_BITS-1:0]    b_dat_i,
   output logic [tart_pkg::BUS_BITS-1:0]    b_dat_o,
   output logic                             b_ack_o,

   // Antenna samples
   input  logic                             ax_valid_i,
   input  logic [tart_pkg::NUM_ANTENNA-1:0] antenna_i,

   // Block status
   output logic                             newblock_o,
   output logic                             available_o
);
   import tart_pkg::*;

   logic                       enable;
   logic                       overwrite;
   logic [BLOCK_LOG2_BITS-1:0] block_log2;

   corr_feed_if feed_if ();  // Fanout, correlators and bank
   vis_read_if  rd_if ();    // Register file and bank

   // --------------------------------------------------------------------------
   // Bus slave
   // --------------------------------------------------------------------------
   tart_control_regs u_regs (
      .b_clk        (b_clk),
      .rst_i        (rst_i),
      .b_cyc_i      (b_cyc_i),
      .b_stb_i      (b_stb_i),
      .b_we_i       (b_we_i),
      .b_adr_i      (b_adr_i),
      .b_dat_i      (b_dat_i),
      .b_dat_o      (b_dat_o),
      .b_ack_o      (b_ack_o),
      .enable_o     (enable),
      .overwrite_o  (overwrite),
      .block_log2_o (block_log2),
      .rd           (rd_if.regs)
   );

   // --------------------------------------------------------------------------
   // Correlator datapath
   // --------------------------------------------------------------------------
   baseline_fanout u_fanout (
      .b_clk        (b_clk),
      .rst_i        (rst_i),
      .enable_i     (enable),
      .block_log2_i (block_log2),
      .ax_valid_i   (ax_valid_i),
      .antenna_i    (antenna_i),
      .feed         (feed_if.fanout)
   );

   for (genvar k = 0; k < NUM_BASELINES; k++) begin : g_corr
      baseline_correlator #(.IDX(k)) u_corr (
         .b_clk (b_clk),
         .rst_i (rst_i),
         .feed  (feed_if.correlator)
      );
   end

   visibility_bank u_bank (
      .b_clk       (b_clk),
      .rst_i       (rst_i),
      .overwrite_i (overwrite),
      .feed        (feed_if.bank),
      .rd          (rd_if.bank),
      .newblock_o  (newblock_o)
   );

   assign available_o = rd_if.available;

endmodule

`default_nettype wire

/* verification/tart_assertions.sv */
`default_nettype none

module tart_assertions (
   input logic b_clk,
   input logic rst_i,
   input logic b_cyc_i,
   input logic b_stb_i,
   input logic b_ack_o,
   input logic newblock_o,
   input logic available_o
);

   int fail_count = 0;  // Failed properties so far

   // --------------------------------------------------------------------------
   // Bus handshake
   // --------------------------------------------------------------------------
   ack_needs_request: assert property (@(posedge b_clk) disable iff (rst_i)
      b_ack_o |-> $past(b_cyc_i && b_stb_i))  // Only for a live strobe
      else begin
         fail_count++;
         $error("Acknowledge without a bus request");
      end

   ack_single_cycle: assert property (@(posedge b_clk) disable iff (rst_i)
      b_ack_o |=> !b_ack_o)
      else begin
         fail_count++;
         $error("Acknowledge held for two cycles");
      end

   // --------------------------------------------------------------------------
   // Block strobes
   // --------------------------------------------------------------------------
   newblock_single_cycle: assert property (@(posedge b_clk) disable iff (rst_i)
      newblock_o |=> !newblock_o)
      else begin
         fail_count++;
         $error("New-block strobe longer than one cycle");
      end

   // Flag rises together with the strobe of a stored block
   available_after_newblock: assert property (@(posedge b_clk) disable iff (rst_i)
      $rose(available_o) |-> newblock_o)
      else begin
         fail_count++;
         $error("Available flag rose without a new block");
      end

endmodule

bind tart_correlator_top tart_assertions u_assertions (
   .b_clk       (b_clk),
   .rst_i       (rst_i),
   .b_cyc_i     (b_cyc_i),
   .b_stb_i     (b_stb_i),
   .b_ack_o     (b_ack_o),
   .newblock_o  (newblock_o),
   .available_o (available_o)
);

`default_nettype wire

/* verification/tb_tart.sv */
`default_nettype none

module tb_tart;
   import tart_pkg::*;

   localparam int          HALF_PERIOD   = 20;
   localparam int          RESET_CYCLES  = 10;
   localparam int          BUS_TIMEOUT   = 8;     // Cycles to wait for an acknowledge
   localparam int          BLOCK_TIMEOUT = 20;    // Cycles or polls for block events
   localparam int          NEWBLOCK_LAT  = 3;     // Sampling edge to strobe
   localparam logic [31:0] LFSR_SEED     = 32'h4914ccd8;
   localparam logic [31:0] LFSR_TAPS     = 32'h80200003;  // x^32+x^22+x^2+x+1

   logic                   b_clk;
   logic                   rst_i;
   logic                   b_cyc_i;
   logic                   b_stb_i;
   logic                   b_we_i;
   logic [ADR_BITS-1:0]    b_adr_i;
   logic [BUS_BITS-1:0]    b_dat_i;
   logic [BUS_BITS-1:0]    b_dat_o;
   logic                   b_ack_o;
   logic                   ax_valid_i;
   logic [NUM_ANTENNA-1:0] antenna_i;
   logic                   newblock_o;
   logic                   available_o;

   logic [31:0] lfsr;                       // Random source state
   int          model_vis [NUM_BASELINES];  // Agreements of the last fed block
   int          saved_vis [NUM_BASELINES];
   int          blocks_stored;              // Expected block counter

   always #HALF_PERIOD b_clk = ~b_clk;

   tart_correlator_top dut_i (
      .b_clk       (b_clk),
      .rst_i       (rst_i),
      .b_cyc_i     (b_cyc_i),
      .b_stb_i     (b_stb_i),
      .b_we_i      (b_we_i),
      .b_adr_i     (b_adr_i),
      .b_dat_i     (b_dat_i),
      .b_dat_o     (b_dat_o),
      .b_ack_o     (b_ack_o),
      .ax_valid_i  (ax_valid_i),
      .antenna_i   (antenna_i),
      .newblock_o  (newblock_o),
      .available_o (available_o)
   );

   // --------------------------------------------------------------------------
   // Helpers
   // --------------------------------------------------------------------------
   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "Simulation stopped on first error");
   endtask

   // One Galois step per bit taken
   function automatic logic take_bit();
      logic b;
      b    = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      return b;
   endfunction

   // {count, 00, overflow, available}
   function automatic logic [7:0] status_byte(input int blocks, input logic ovf,
                                              input logic avail);
      return {4'(blocks), 2'b00, ovf, avail};
   endfunction

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp,
                             input string what);
      assert (got === exp)
         else stop_run($sformatf("[ERROR] %0t: %s is 0x%02h, expected 0x%02h",
                                 $time, what, got, exp));
   endtask

   task automatic bus_cycle(input logic we, input logic [ADR_BITS-1:0] adr,
                            input logic [BUS_BITS-1:0] wdat,
                            output logic [BUS_BITS-1:0] rdat);
      int waited;
      waited = 0;
      @(negedge b_clk);
      b_cyc_i = 1'b1;
      b_stb_i = 1'b1;
      b_we_i  = we;
      b_adr_i = adr;
      b_dat_i = wdat;
      @(negedge b_clk);
      while (!b_ack_o) begin
         if (waited == BUS_TIMEOUT)
            stop_run($sformatf("Timeout: no bus acknowledge at address %0d", adr));
         @(negedge b_clk);
         waited++;
      end
      rdat    = b_dat_o;  // Valid with the acknowledge
      b_cyc_i = 1'b0;
      b_stb_i = 1'b0;
      b_we_i  = 1'b0;
      assert (waited == 0)
         else stop_run($sformatf("[ERROR] %0t: acknowledge %0d cycles late", $time, waited));
   endtask

   task automatic bus_write(input logic [ADR_BITS-1:0] adr, input logic [BUS_BITS-1:0] dat);
      logic [BUS_BITS-1:0] unused;
      bus_cycle(1'b1, adr, dat, unused);
   endtask

   task automatic bus_read(input logic [ADR_BITS-1:0] adr, output logic [BUS_BITS-1:0] dat);
      bus_cycle(1'b0, adr, '0, dat);
   endtask

   task automatic expect_reg(input logic [ADR_BITS-1:0] adr, input logic [7:0] exp);
      logic [BUS_BITS-1:0] got;
      bus_read(adr, got);
      check_byte(got, exp, $sformatf("register %0d", adr));
   endtask

   // Random samples with idle gaps and a per-pair agreement model
   task automatic feed_block(input int n);
      logic [NUM_ANTENNA-1:0] smp;
      logic                   gap_a;
      logic                   gap_b;
      int                     k;
      for (int j = 0; j < NUM_BASELINES; j++) begin
         model_vis[j] = 0;
      end
      for (int i = 0; i < n; i++) begin
         gap_a = take_bit();
         gap_b = take_bit();
         if (gap_a && gap_b) begin  // One idle cycle in four
            @(negedge b_clk);
            ax_valid_i = 1'b0;
         end
         for (int a = 0; a < NUM_ANTENNA; a++) begin
            smp[a] = take_bit();
         end
         @(negedge b_clk);
         ax_valid_i = 1'b1;
         antenna_i  = smp;
         k = 0;
         for (int a = 0; a < NUM_ANTENNA; a++) begin  // Pairs (0,1) (0,2) ... (2,3)
            for (int b = a + 1; b < NUM_ANTENNA; b++) begin
               if (smp[a] == smp[b]) begin
                  model_vis[k]++;
               end
               k++;
            end
         end
      end
      @(negedge b_clk);  // Last sample taken on the edge before
      ax_valid_i = 1'b0;
   endtask

   task automatic wait_newblock();
      int lat;
      lat = 0;
      while (!newblock_o) begin
         if (lat == BLOCK_TIMEOUT)
            stop_run("Timeout: newblock_o did not pulse after a finished block");
         @(negedge b_clk);
         lat++;
      end
      assert (lat == NEWBLOCK_LAT)
         else stop_run($sformatf("[ERROR] %0t: newblock_o after %0d cycles, expected %0d",
                                 $time, lat, NEWBLOCK_LAT));
      blocks_stored++;
   endtask

   task automatic wait_overflow();
      logic [BUS_BITS-1:0] st;
      int                  polls;
      polls = 0;
      bus_read(ADR_STATUS, st);
      while (!st[1]) begin
         if (polls == BLOCK_TIMEOUT)
            stop_run("Timeout: overflow flag never set after a dropped block");
         bus_read(ADR_STATUS, st);
         polls++;
      end
   endtask

   // Twelve bytes, low then high per baseline
   task automatic check_vis(input int exp [NUM_BASELINES]);
      logic [BUS_BITS-1:0] got;
      logic [15:0]         word;
      for (int k = 0; k < NUM_BASELINES; k++) begin
         word = 16'(exp[k]);
         for (int h = 0; h < 2; h++) begin
            bus_read(ADR_BITS'(int'(ADR_VIS_BASE) + 2 * k + h), got);
            check_byte(got, h ? word[15:8] : word[7:0],
                       $sformatf("baseline %0d byte %0d", k, h));
         end
      end
   endtask

   // --------------------------------------------------------------------------
   // Directed tests
   // --------------------------------------------------------------------------
   task automatic test_reset_defaults();
      check_byte(8'(available_o), 8'd0, "available_o after reset");
      check_byte(8'(newblock_o), 8'd0, "newblock_o after reset");
      expect_reg(ADR_CTRL, 8'd0);
      expect_reg(ADR_BLOCK, 8'd4);
      expect_reg(ADR_STATUS, 8'd0);
   endtask

   task automatic test_register_access();
      bus_write(ADR_CTRL, 8'h02);  // Overwrite only
      expect_reg(ADR_CTRL, 8'h02);
      bus_write(ADR_CTRL, 8'h01);  // Enable only
      expect_reg(ADR_CTRL, 8'h01);
      bus_write(ADR_BLOCK, 8'd7);
      expect_reg(ADR_BLOCK, 8'd7);
      bus_write(ADR_BLOCK, 8'd15);  // Clamped
      expect_reg(ADR_BLOCK, 8'd12);
      expect_reg(ADR_BITS'(3), 8'd0);
      expect_reg(ADR_BITS'(28), 8'd0);  // Past the visibility window
      bus_write(ADR_CTRL, 8'h00);
      bus_write(ADR_BLOCK, 8'd4);
   endtask

   task automatic test_one_block();
      bus_write(ADR_CTRL, 8'h01);
      feed_block(16);
      wait_newblock();
      check_byte(8'(available_o), 8'd1, "available_o after a block");
      check_vis(model_vis);
      check_byte(8'(available_o), 8'd0, "available_o after the last byte");
      expect_reg(ADR_STATUS, status_byte(blocks_stored, 1'b0, 1'b0));
   endtask

   task automatic test_overflow();
      feed_block(16);
      saved_vis = model_vis;
      wait_newblock();
      feed_block(16);  // Finds the bank full
      wait_overflow();
      expect_reg(ADR_STATUS, status_byte(blocks_stored, 1'b1, 1'b1));
      check_vis(saved_vis);
      bus_write(ADR_STATUS, 8'h00);
      expect_reg(ADR_STATUS, status_byte(blocks_stored, 1'b0, 1'b0));
   endtask

   task automatic test_overwrite();
      bus_write(ADR_CTRL, 8'h03);
      feed_block(16);
      wait_newblock();
      feed_block(16);
      wait_newblock();
      expect_reg(ADR_STATUS, status_byte(blocks_stored, 1'b0, 1'b1));
      check_vis(model_vis);  // Second block only
   endtask

   task automatic test_block_size();
      bus_write(ADR_CTRL, 8'h00);
      bus_write(ADR_BLOCK, 8'd5);
      bus_write(ADR_CTRL, 8'h01);
      feed_block(20);              // Partial, thrown away below
      bus_write(ADR_CTRL, 8'h00);
      bus_write(ADR_CTRL, 8'h01);
      feed_block(32);
      wait_newblock();
      check_vis(model_vis);
      expect_reg(ADR_STATUS, status_byte(blocks_stored, 1'b0, 1'b0));
   endtask

   initial begin
      b_clk         = 1'b0;
      rst_i         = 1'b1;
      b_cyc_i       = 1'b0;
      b_stb_i       = 1'b0;
      b_we_i        = 1'b0;
      b_adr_i       = '0;
      b_dat_i       = '0;
      ax_valid_i    = 1'b0;
      antenna_i     = '0;
      lfsr          = LFSR_SEED;
      blocks_stored = 0;
      repeat (RESET_CYCLES) @(negedge b_clk);
      rst_i = 1'b0;

      test_reset_defaults();
      test_register_access();
      test_one_block();
      test_overflow();
      test_overwrite();
      test_block_size();

      if (dut_i.u_assertions.fail_count != 0) begin
         stop_run($sformatf("%0d bound assertion failures during the run",
                            dut_i.u_assertions.fail_count));
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* sim.f */
rtl/tart_pkg.sv
rtl/tart_ifs.sv
rtl/baseline_fanout.sv
rtl/baseline_correlator.sv
rtl/visibility_bank.sv
rtl/tart_control_regs.sv
rtl/tart_correlator_top.sv
verification/tart_assertions.sv
verification/tb_tart.sv

/* Makefile */
# Verilator flow for the visibility correlator

VERILATOR ?= verilator
TOP       ?= tb_tart
LOG       ?= sim.log
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

SIM_FLAGS  = --binary --timing --assert -Wno-fatal
SIM_FLAGS += --top-module $(TOP) -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "TEST PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
